/* include/be_params.svh */
// Integer issue stage parameters
// Widths, register count, front-end exception codes and the
// RV64 base opcodes used by predecode and decode
`ifndef BE_PARAMS_SVH
`define BE_PARAMS_SVH

`define BE_VADDR_W     39
`define BE_DWORD_W     64
`define BE_INSTR_W     32
`define BE_REG_ADDR_W  5
`define BE_REG_NUM     32
`define BE_EXC_CODE_W  4

// Front-end exception code for an illegal instruction
`define BE_EXC_ILLEGAL_INSTR 4'd2

`define BE_OP_LOAD     7'b0000011
`define BE_OP_STORE    7'b0100011
`define BE_OP_AMO      7'b0101111
`define BE_OP_BRANCH   7'b1100011
`define BE_OP_JAL      7'b1101111
`define BE_OP_JALR     7'b1100111
`define BE_OP_LUI      7'b0110111
`define BE_OP_AUIPC    7'b0010111
`define BE_OP_IMM      7'b0010011
`define BE_OP_IMM_32   7'b0011011
`define BE_OP_OP       7'b0110011
`define BE_OP_OP_32    7'b0111011
`define BE_OP_SYSTEM   7'b1110011
`define BE_OP_MISC_MEM 7'b0001111

`endif

/* source/be_pkg.sv */
// Integer issue stage types
// Fetch queue message, issue and decode packets, writeback and
// dispatch packets shared by the scheduler and its submodules
`include "be_params.svh"

package be_pkg;

  typedef enum logic
  {
    e_fe_fetch     = 1'b0,
    e_fe_exception = 1'b1
  } be_fe_msg_type_e;

  typedef struct packed
  {
    logic [`BE_VADDR_W-1:0] pc;
    logic [`BE_INSTR_W-1:0] instr;
  } be_fe_fetch_s;

  // Padded so both message views are the same width
  typedef struct packed
  {
    logic [`BE_VADDR_W-1:0]               vaddr;
    logic [`BE_EXC_CODE_W-1:0]            exception_code;
    logic [`BE_INSTR_W-`BE_EXC_CODE_W-1:0] padding;
  } be_fe_exception_s;

  typedef union packed
  {
    be_fe_fetch_s     fetch;
    be_fe_exception_s exception;
  } be_fe_msg_u;

  typedef struct packed
  {
    be_fe_msg_type_e msg_type;
    be_fe_msg_u      msg;
  } be_fe_queue_s;

  typedef struct packed
  {
    logic                      fe_exception_not_instr;
    logic [`BE_EXC_CODE_W-1:0] fe_exception_code;
    logic [`BE_VADDR_W-1:0]    pc;
    logic [`BE_INSTR_W-1:0]    instr;
    logic                      mem_v;
    logic                      fence_v;
    logic                      irs1_v;
    logic                      irs2_v;
    logic [`BE_DWORD_W-1:0]    imm;
  } be_issue_pkt_s;

  typedef enum logic [2:0]
  {
    e_fu_alu    = 3'd0,
    e_fu_mem    = 3'd1,
    e_fu_branch = 3'd2,
    e_fu_jump   = 3'd3,
    e_fu_system = 3'd4,
    e_fu_none   = 3'd5
  } be_fu_e;

  typedef enum logic [3:0]
  {
    e_alu_add    = 4'd0,
    e_alu_sub    = 4'd1,
    e_alu_sll    = 4'd2,
    e_alu_slt    = 4'd3,
    e_alu_sltu   = 4'd4,
    e_alu_xor    = 4'd5,
    e_alu_srl    = 4'd6,
    e_alu_sra    = 4'd7,
    e_alu_or     = 4'd8,
    e_alu_and    = 4'd9,
    e_alu_pass_b = 4'd10
  } be_alu_op_e;

  typedef struct packed
  {
    be_fu_e                    fu;
    be_alu_op_e                alu_op;
    logic                      rd_w_v;
    logic [`BE_REG_ADDR_W-1:0] rd_addr;
    logic                      load_v;
    logic                      store_v;
    logic                      opw_v;
    logic                      illegal_instr_v;
    logic                      fe_exception_v;
  } be_decode_s;

  typedef struct packed
  {
    logic                      rd_w_v;
    logic [`BE_REG_ADDR_W-1:0] rd_addr;
    logic [`BE_DWORD_W-1:0]    rd_data;
  } be_wb_pkt_s;

  typedef struct packed
  {
    logic                   v;
    logic                   poison;
    logic [`BE_VADDR_W-1:0] pc;
    logic [`BE_INSTR_W-1:0] instr;
    logic [`BE_DWORD_W-1:0] rs1;
    logic [`BE_DWORD_W-1:0] rs2;
    logic [`BE_DWORD_W-1:0] imm;
    be_decode_s             decode;
  } be_dispatch_pkt_s;

endpackage

/* source/be_regfile.sv */
// Integer register file
// 31 writable 64-bit registers with x0 tied to zero, one write port
// from writeback and two registered read ports with write bypass
`timescale 1ns/100ps
`include "be_params.svh"

module be_regfile
  (input  logic                            clk_i
  , input  logic                            rst_n_i
  , input  be_pkg::be_wb_pkt_s              wb_pkt_i
  , input  logic                            rs1_r_v_i
  , input  logic [`BE_REG_ADDR_W-1:0]       rs1_addr_i
  , input  logic                            rs2_r_v_i
  , input  logic [`BE_REG_ADDR_W-1:0]       rs2_addr_i
  , output logic [`BE_DWORD_W-1:0]          rs1_data_o
  , output logic [`BE_DWORD_W-1:0]          rs2_data_o
  );

  logic [`BE_DWORD_W-1:0]    rf_q [1:`BE_REG_NUM-1];
  logic [1:0]                r_v;
  logic [`BE_REG_ADDR_W-1:0] r_addr [2];
  logic [`BE_DWORD_W-1:0]    r_data_q [2];

  assign r_v       = {rs2_r_v_i, rs1_r_v_i};
  assign r_addr[0] = rs1_addr_i;
  assign r_addr[1] = rs2_addr_i;

  // Writes to x0 are dropped
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      for (int i = 1; i < `BE_REG_NUM; i++)
        rf_q[i] <= '0;
    end
    else if (wb_pkt_i.rd_w_v && (wb_pkt_i.rd_addr != '0))
      rf_q[wb_pkt_i.rd_addr] <= wb_pkt_i.rd_data;
  end

  for (genvar p = 0; p < 2; p++)
  begin : g_rd_port
    logic wr_hit;

    assign wr_hit = wb_pkt_i.rd_w_v && (wb_pkt_i.rd_addr == r_addr[p]);

    // Data is held when the port is not enabled
    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
      if (!rst_n_i)
        r_data_q[p] <= '0;
      else if (r_v[p])
      begin
        if (r_addr[p] == '0)
          r_data_q[p] <= '0;
        else if (wr_hit)
          r_data_q[p] <= wb_pkt_i.rd_data;
        else
          r_data_q[p] <= rf_q[r_addr[p]];
      end
    end

    a_x0_reads_zero : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (r_v[p] && (r_addr[p] == '0)) |=> (r_data_q[p] == '0));
  end

  assign rs1_data_o = r_data_q[0];
  assign rs2_data_o = r_data_q[1];

endmodule

/* source/be_instr_decoder.sv */
// Instruction decoder
// Combinational decode of the issued RV64I instruction into functional
// unit, ALU operation and register write controls; front-end
// exceptions decode to no unit
`timescale 1ns/100ps
`include "be_params.svh"

module be_instr_decoder
  (input  logic                      fe_exc_not_instr_i
  , input  logic [`BE_EXC_CODE_W-1:0] fe_exc_i
  , input  logic [`BE_INSTR_W-1:0]    instr_i
  , output be_pkg::be_decode_s        decode_o
  );

  import be_pkg::*;

  logic [6:0]                opcode;
  logic [2:0]                funct3;
  logic [6:0]                funct7;
  logic [`BE_REG_ADDR_W-1:0] rd;
  logic                      funct7_ok;
  logic                      word_funct3_ok;
  be_decode_s                decode;

  assign opcode = instr_i[6:0];
  assign rd     = instr_i[11:7];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // Base encodings allow funct7 of zero, or bit 30 for sub and sra
  assign funct7_ok = (funct7 == 7'b0000000)
                     || ((funct7 == 7'b0100000) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
  assign word_funct3_ok = (funct3 == 3'b000) || (funct3 == 3'b001) || (funct3 == 3'b101);

  function automatic be_alu_op_e alu_op_f(input logic [2:0] f3, input logic alt);
    be_alu_op_e op;
    case (f3)
      3'b000:  op = alt ? e_alu_sub : e_alu_add;
      3'b001:  op = e_alu_sll;
      3'b010:  op = e_alu_slt;
      3'b011:  op = e_alu_sltu;
      3'b100:  op = e_alu_xor;
      3'b101:  op = alt ? e_alu_sra : e_alu_srl;
      3'b110:  op = e_alu_or;
      default: op = e_alu_and;
    endcase
    return op;
  endfunction

  always_comb
  begin
    decode         = '0;
    decode.fu      = e_fu_none;
    decode.alu_op  = e_alu_add;
    decode.rd_addr = rd;
    if (fe_exc_not_instr_i)
    begin
      decode.fe_exception_v  = 1'b1;
      decode.illegal_instr_v = (fe_exc_i == `BE_EXC_ILLEGAL_INSTR);
    end
    else
    begin
      case (opcode)
        `BE_OP_LOAD:
        begin
          decode.fu     = e_fu_mem;
          decode.load_v = 1'b1;
          decode.rd_w_v = 1'b1;
        end
        `BE_OP_STORE:
        begin
          decode.fu      = e_fu_mem;
          decode.store_v = 1'b1;
        end
        // AMOs both read and write memory
        `BE_OP_AMO:
        begin
          decode.fu      = e_fu_mem;
          decode.load_v  = 1'b1;
          decode.store_v = 1'b1;
          decode.rd_w_v  = 1'b1;
          decode.opw_v   = (funct3 == 3'b010);
        end
        `BE_OP_BRANCH:
        begin
          decode.fu              = e_fu_branch;
          decode.alu_op          = funct3[2] ? (funct3[1] ? e_alu_sltu : e_alu_slt) : e_alu_sub;
          decode.illegal_instr_v = (funct3[2:1] == 2'b01);
        end
        `BE_OP_JAL, `BE_OP_JALR:
        begin
          decode.fu              = e_fu_jump;
          decode.rd_w_v          = 1'b1;
          decode.illegal_instr_v = (opcode == `BE_OP_JALR) && (funct3 != 3'b000);
        end
        `BE_OP_LUI:
        begin
          decode.fu     = e_fu_alu;
          decode.alu_op = e_alu_pass_b;
          decode.rd_w_v = 1'b1;
        end
        `BE_OP_AUIPC, `BE_OP_IMM, `BE_OP_IMM_32:
        begin
          decode.fu     = e_fu_alu;
          decode.rd_w_v = 1'b1;
          if (opcode != `BE_OP_AUIPC)
            decode.alu_op = alu_op_f(funct3, (funct3 == 3'b101) && instr_i[30]);
          decode.opw_v           = (opcode == `BE_OP_IMM_32);
          decode.illegal_instr_v = (opcode == `BE_OP_IMM_32) && !word_funct3_ok;
        end
        `BE_OP_OP, `BE_OP_OP_32:
        begin
          decode.fu              = e_fu_alu;
          decode.rd_w_v          = 1'b1;
          decode.alu_op          = alu_op_f(funct3, instr_i[30]);
          decode.opw_v           = (opcode == `BE_OP_OP_32);
          decode.illegal_instr_v = !funct7_ok || ((opcode == `BE_OP_OP_32) && !word_funct3_ok);
        end
        // Only the CSR forms write rd
        `BE_OP_SYSTEM:
        begin
          decode.fu     = e_fu_system;
          decode.rd_w_v = (funct3 != 3'b000);
        end
        `BE_OP_MISC_MEM:
          decode.fu = e_fu_mem;
        default:
          decode.illegal_instr_v = 1'b1;
      endcase
      decode.rd_w_v = decode.rd_w_v && (rd != '0);
    end
  end

  assign decode_o = decode;

endmodule

/* source/be_scheduler.sv */
// Integer issue scheduler
// Accepts fetch queue entries with a valid/yumi handshake, predecodes
// them, reads the register file on acceptance and holds one entry in
// the issue register until the calculator takes it. A flush poisons
// the held entry
`timescale 1ns/100ps
`include "be_params.svh"

module be_scheduler
  (input  logic                      clk_i
  , input  logic                      rst_n_i
  , input  be_pkg::be_fe_queue_s      fe_queue_i
  , input  logic                      fe_queue_v_i
  , output logic                      fe_queue_yumi_o
  , input  logic                      flush_i
  , input  logic                      dispatch_v_i
  , input  be_pkg::be_wb_pkt_s        wb_pkt_i
  , output be_pkg::be_dispatch_pkt_s  dispatch_pkt_o
  );

  import be_pkg::*;

  logic [`BE_INSTR_W-1:0] fetch_instr;
  logic [6:0]             opcode;
  be_issue_pkt_s          issue_pkt;
  be_issue_pkt_s          issue_pkt_r;
  logic                   issue_v_r;
  logic                   poison_r;
  logic                   accept;
  logic [`BE_DWORD_W-1:0] irf_rs1;
  logic [`BE_DWORD_W-1:0] irf_rs2;
  be_decode_s             decoded;
  be_dispatch_pkt_s       dispatch_pkt;

  assign fetch_instr = fe_queue_i.msg.fetch.instr;
  assign opcode      = fetch_instr[6:0];

  // Room when empty or when the held entry leaves this cycle
  assign accept          = fe_queue_v_i && !flush_i && (!issue_v_r || dispatch_v_i);
  assign fe_queue_yumi_o = accept;

  always_comb
  begin
    issue_pkt = '0;
    if (fe_queue_i.msg_type == e_fe_fetch)
    begin
      issue_pkt.pc    = fe_queue_i.msg.fetch.pc;
      issue_pkt.instr = fetch_instr;

      issue_pkt.mem_v = (opcode == `BE_OP_LOAD) || (opcode == `BE_OP_STORE)
                        || (opcode == `BE_OP_AMO);
      // fence and fence.i, plus sfence.vma
      issue_pkt.fence_v = (opcode == `BE_OP_MISC_MEM)
                          || ((opcode == `BE_OP_SYSTEM) && (fetch_instr[31:25] == 7'b0001001)
                              && (fetch_instr[14:12] == 3'b000));

      case (opcode)
        `BE_OP_JALR, `BE_OP_LOAD, `BE_OP_IMM, `BE_OP_IMM_32, `BE_OP_SYSTEM:
          issue_pkt.irs1_v = 1'b1;
        `BE_OP_BRANCH, `BE_OP_STORE, `BE_OP_OP, `BE_OP_OP_32, `BE_OP_AMO:
        begin
          issue_pkt.irs1_v = 1'b1;
          issue_pkt.irs2_v = 1'b1;
        end
        default:
        begin
        end
      endcase

      case (opcode)
        `BE_OP_LUI, `BE_OP_AUIPC:
          issue_pkt.imm = {{32{fetch_instr[31]}}, fetch_instr[31:12], 12'b0};
        `BE_OP_JAL:
          issue_pkt.imm = {{44{fetch_instr[31]}}, fetch_instr[19:12], fetch_instr[20],
                           fetch_instr[30:21], 1'b0};
        `BE_OP_BRANCH:
          issue_pkt.imm = {{52{fetch_instr[31]}}, fetch_instr[7], fetch_instr[30:25],
                           fetch_instr[11:8], 1'b0};
        `BE_OP_STORE:
          issue_pkt.imm = {{53{fetch_instr[31]}}, fetch_instr[30:25], fetch_instr[11:7]};
        `BE_OP_JALR, `BE_OP_LOAD, `BE_OP_IMM, `BE_OP_IMM_32:
          issue_pkt.imm = {{53{fetch_instr[31]}}, fetch_instr[30:20]};
        // CSR immediate is the rs1 field, zero extended
        `BE_OP_SYSTEM:
          issue_pkt.imm = {{(`BE_DWORD_W-5){1'b0}}, fetch_instr[19:15]};
        default:
        begin
        end
      endcase
    end
    else
    begin
      issue_pkt.fe_exception_not_instr = 1'b1;
      issue_pkt.fe_exception_code      = fe_queue_i.msg.exception.exception_code;
      issue_pkt.pc                     = fe_queue_i.msg.exception.vaddr;
    end
  end

  // Entry and poison state, replaced on accept, cleared on dispatch
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      issue_v_r <= 1'b0;
      poison_r  <= 1'b0;
    end
    else if (accept)
    begin
      issue_v_r <= 1'b1;
      poison_r  <= 1'b0;
    end
    else if (issue_v_r && dispatch_v_i)
    begin
      issue_v_r <= 1'b0;
      poison_r  <= 1'b0;
    end
    else if (issue_v_r && flush_i)
      poison_r <= 1'b1;
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
      issue_pkt_r <= issue_pkt;
  end

  be_regfile int_regfile
    (.clk_i(clk_i)
    , .rst_n_i(rst_n_i)
    , .wb_pkt_i(wb_pkt_i)
    , .rs1_r_v_i(accept && issue_pkt.irs1_v)
    , .rs1_addr_i(issue_pkt.instr[19:15])
    , .rs2_r_v_i(accept && issue_pkt.irs2_v)
    , .rs2_addr_i(issue_pkt.instr[24:20])
    , .rs1_data_o(irf_rs1)
    , .rs2_data_o(irf_rs2)
    );

  be_instr_decoder instr_decoder
    (.fe_exc_not_instr_i(issue_pkt_r.fe_exception_not_instr)
    , .fe_exc_i(issue_pkt_r.fe_exception_code)
    , .instr_i(issue_pkt_r.instr)
    , .decode_o(decoded)
    );

  // A flush in the dispatch cycle also poisons the outgoing entry
  always_comb
  begin
    dispatch_pkt.v      = issue_v_r && dispatch_v_i;
    dispatch_pkt.poison = poison_r || flush_i;
    dispatch_pkt.pc     = issue_pkt_r.pc;
    dispatch_pkt.instr  = issue_pkt_r.instr;
    dispatch_pkt.rs1    = irf_rs1;
    dispatch_pkt.rs2    = irf_rs2;
    dispatch_pkt.imm    = issue_pkt_r.imm;
    dispatch_pkt.decode = decoded;
  end

  assign dispatch_pkt_o = dispatch_pkt;

  a_yumi_loads_entry : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    fe_queue_yumi_o |-> fe_queue_v_i ##1 issue_v_r);

  a_dispatch_has_entry : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dispatch_pkt_o.v |-> issue_v_r && !$isunknown(dispatch_pkt_o.decode.fu));

  // Predecode and full decode agree on memory ops; sfence.vma is a system op
  a_mem_decodes_mem : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (dispatch_pkt_o.v && (issue_pkt_r.mem_v
        || (issue_pkt_r.fence_v && (issue_pkt_r.instr[6:0] == `BE_OP_MISC_MEM))))
      |-> (dispatch_pkt_o.decode.fu == e_fu_mem));

endmodule

/* source/be_issue_top.sv */
// Integer issue stage
// Brings out the fetch queue handshake, the writeback port and the
// dispatch packet of the scheduler
`timescale 1ns/100ps

module be_issue_top
  (input  logic                      clk_i
  , input  logic                      rst_n_i

  // Fetch queue
  , input  be_pkg::be_fe_queue_s      fe_queue_i
  , input  logic                      fe_queue_v_i
  , output logic                      fe_queue_yumi_o

  // Calculator control
  , input  logic                      flush_i
  , input  logic                      dispatch_v_i

  // Writeback into the register file
  , input  be_pkg::be_wb_pkt_s        wb_pkt_i

  // Dispatch to the calculator
  , output be_pkg::be_dispatch_pkt_s  dispatch_pkt_o
  );

  be_scheduler scheduler
    (.clk_i(clk_i)
    , .rst_n_i(rst_n_i)
    , .fe_queue_i(fe_queue_i)
    , .fe_queue_v_i(fe_queue_v_i)
    , .fe_queue_yumi_o(fe_queue_yumi_o)
    , .flush_i(flush_i)
    , .dispatch_v_i(dispatch_v_i)
    , .wb_pkt_i(wb_pkt_i)
    , .dispatch_pkt_o(dispatch_pkt_o)
    );

endmodule

/* tb/tb_be_issue.sv */
// Testbench for the integer issue stage
// Replays the golden sequence of register writes, fetch entries,
// exception entries and flushes, checking every dispatch packet
`timescale 1ns/100ps
`include "be_params.svh"

module tb_be_issue;

  import be_pkg::*;

  localparam int WAIT_LIMIT  = 32;
  localparam int DRIVE_DELAY = 2;

  // Expected contents of the entry held in the issue register
  typedef struct packed
  {
    logic [`BE_VADDR_W-1:0]    pc;
    logic [`BE_INSTR_W-1:0]    instr;
    logic [`BE_DWORD_W-1:0]    rs1;
    logic [`BE_DWORD_W-1:0]    rs2;
    logic [`BE_DWORD_W-1:0]    imm;
    logic [2:0]                fu;
    logic                      rd_w_v;
    logic                      illegal;
    logic                      exc;
    logic [`BE_EXC_CODE_W-1:0] code;
    logic                      poison;
  } expect_s;

  logic             clk;
  logic             rst_n;
  be_fe_queue_s     fe_queue;
  logic             fe_queue_v;
  logic             fe_queue_yumi;
  logic             flush;
  logic             dispatch_v;
  be_wb_pkt_s       wb_pkt;
  be_dispatch_pkt_s dispatch_pkt;

  expect_s held_exp;
  logic    held_v;

  be_issue_top UUT
    (.clk_i(clk)
    , .rst_n_i(rst_n)
    , .fe_queue_i(fe_queue)
    , .fe_queue_v_i(fe_queue_v)
    , .fe_queue_yumi_o(fe_queue_yumi)
    , .flush_i(flush)
    , .dispatch_v_i(dispatch_v)
    , .wb_pkt_i(wb_pkt)
    , .dispatch_pkt_o(dispatch_pkt)
    );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic abort_run(input string what);
    $display("ERROR at %0d ns: %s", $time, what);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected)
    begin
      $display("FAILED at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
      $display("STATUS: FAIL");
      $fatal(1);
    end
  endtask

  // Inputs change a little after the rising edge
  task automatic step_cycle();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic idle_cycles(input int count);
    repeat (count)
    begin
      @(negedge clk);
      check_value("fe_queue_yumi_o", fe_queue_yumi, 1'b0);
      check_value("dispatch_pkt_o.v", dispatch_pkt.v, 1'b0);
      step_cycle();
    end
  endtask

  task automatic check_dispatch();
    check_value("dispatch_pkt_o.poison", dispatch_pkt.poison, held_exp.poison);
    check_value("dispatch_pkt_o.pc", dispatch_pkt.pc, held_exp.pc);
    check_value("dispatch_pkt_o.decode.fu", dispatch_pkt.decode.fu, held_exp.fu);
    check_value("dispatch_pkt_o.decode.rd_w_v", dispatch_pkt.decode.rd_w_v, held_exp.rd_w_v);
    check_value("dispatch_pkt_o.decode.illegal_instr_v",
                dispatch_pkt.decode.illegal_instr_v, held_exp.illegal);
    check_value("dispatch_pkt_o.decode.fe_exception_v",
                dispatch_pkt.decode.fe_exception_v, held_exp.exc);
    if (held_exp.exc)
      check_value("exception_code", UUT.scheduler.issue_pkt_r.fe_exception_code,
                  held_exp.code);
    else
    begin
      check_value("dispatch_pkt_o.instr", dispatch_pkt.instr, held_exp.instr);
      check_value("dispatch_pkt_o.rs1", dispatch_pkt.rs1, held_exp.rs1);
      check_value("dispatch_pkt_o.rs2", dispatch_pkt.rs2, held_exp.rs2);
      check_value("dispatch_pkt_o.imm", dispatch_pkt.imm, held_exp.imm);
    end
  endtask

  task automatic wait_for_dispatch();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!dispatch_pkt.v)
    begin
      cycles++;
      if (cycles >= WAIT_LIMIT)
        abort_run("no dispatch packet appeared while waiting for the held entry");
      @(negedge clk);
    end
    check_dispatch();
  endtask

  task automatic wait_for_yumi();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!fe_queue_yumi)
    begin
      cycles++;
      if (cycles >= WAIT_LIMIT)
        abort_run("the scheduler never accepted the fetch queue entry");
      @(negedge clk);
    end
  endtask

  // Presents an entry; a held entry first stalls, then dispatches as the new one enters
  task automatic send_entry(input be_fe_queue_s msg, input expect_s rec);
    int stall;
    fe_queue   = msg;
    fe_queue_v = 1'b1;
    if (held_v)
    begin
      stall = $urandom % 4;
      idle_cycles(stall);
      dispatch_v = 1'b1;
      wait_for_dispatch();
      check_value("fe_queue_yumi_o", fe_queue_yumi, 1'b1);
    end
    else
      wait_for_yumi();
    step_cycle();
    fe_queue_v = 1'b0;
    dispatch_v = 1'b0;
    held_v     = 1'b1;
    held_exp   = rec;
  endtask

  task automatic drain_entry();
    if (held_v)
    begin
      dispatch_v = 1'b1;
      wait_for_dispatch();
      step_cycle();
      dispatch_v = 1'b0;
      held_v     = 1'b0;
    end
  endtask

  task automatic flush_held();
    if (!held_v)
      abort_run("flush marker in the golden file with no entry held");
    flush = 1'b1;
    idle_cycles(1);
    flush = 1'b0;
    held_exp.poison = 1'b1;
  endtask

  task automatic write_register(input logic [4:0] addr, input logic [63:0] data);
    wb_pkt.rd_w_v  = 1'b1;
    wb_pkt.rd_addr = addr;
    wb_pkt.rd_data = data;
    step_cycle();
    wb_pkt.rd_w_v = 1'b0;
  endtask

  initial
  begin : stimulus
    logic [8*8-1:0]            kind;
    logic [8*160-1:0]          rest;
    logic [`BE_REG_ADDR_W-1:0] rd_addr;
    logic [`BE_VADDR_W-1:0]    pc;
    logic [`BE_INSTR_W-1:0]    instr;
    logic [`BE_DWORD_W-1:0]    rd_data;
    logic [`BE_DWORD_W-1:0]    rs1;
    logic [`BE_DWORD_W-1:0]    rs2;
    logic [`BE_DWORD_W-1:0]    imm;
    logic [2:0]                fu;
    logic                      rd_w_v;
    logic                      illegal;
    logic [`BE_EXC_CODE_W-1:0] code;
    be_fe_queue_s              msg;
    expect_s                   rec;
    int                        fd;
    int                        n;
    int                        seed_draw;

    rst_n       = 1'b0;
    fe_queue    = '0;
    fe_queue_v  = 1'b0;
    flush       = 1'b0;
    dispatch_v  = 1'b0;
    wb_pkt      = '0;
    held_v      = 1'b0;
    held_exp    = '0;
    seed_draw   = $urandom(32'h37b6ac95);

    repeat (10) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;
    idle_cycles(4);

    fd = $fopen("tb/be_issue_golden.txt", "r");
    if (fd == 0)
      abort_run("cannot open the golden file tb/be_issue_golden.txt");

    while ($fscanf(fd, "%s", kind) == 1)
    begin
      case (kind)
        "#":
          n = $fgets(rest, fd);
        "W":
        begin
          n = $fscanf(fd, "%h %h", rd_addr, rd_data);
          if (n != 2)
            abort_run("malformed W record in the golden file");
          drain_entry();
          write_register(rd_addr, rd_data);
        end
        "F":
        begin
          n = $fscanf(fd, "%h %h %h %h %h %h %h %h",
                      pc, instr, rs1, rs2, imm, fu, rd_w_v, illegal);
          if (n != 8)
            abort_run("malformed F record in the golden file");
          msg                 = '0;
          msg.msg_type        = e_fe_fetch;
          msg.msg.fetch.pc    = pc;
          msg.msg.fetch.instr = instr;
          rec         = '0;
          rec.pc      = pc;
          rec.instr   = instr;
          rec.rs1     = rs1;
          rec.rs2     = rs2;
          rec.imm     = imm;
          rec.fu      = fu;
          rec.rd_w_v  = rd_w_v;
          rec.illegal = illegal;
          send_entry(msg, rec);
        end
        "E":
        begin
          n = $fscanf(fd, "%h %h %h", pc, code, illegal);
          if (n != 3)
            abort_run("malformed E record in the golden file");
          msg                              = '0;
          msg.msg_type                     = e_fe_exception;
          msg.msg.exception.vaddr          = pc;
          msg.msg.exception.exception_code = code;
          rec         = '0;
          rec.pc      = pc;
          rec.fu      = e_fu_none;
          rec.illegal = illegal;
          rec.exc     = 1'b1;
          rec.code    = code;
          send_entry(msg, rec);
        end
        "X":
          flush_held();
        default:
          abort_run("unknown record kind in the golden file");
      endcase
    end
    $fclose(fd);

    drain_entry();
    idle_cycles(3);

    $display("STATUS: PASS");
    $finish;
  end

endmodule

/* tb/be_issue_golden.txt */
# Issue stage golden sequence, one operation per line, all fields hex
# W rd data | F pc instr rs1 rs2 imm fu rd_w_v illegal | E vaddr code illegal | X flush held entry
# fu codes are 0 alu, 1 mem, 2 branch, 3 jump, 4 system, 5 none
# Registers still at reset value
F 0000001000 002081b3 0000000000000000 0000000000000000 0000000000000000 0 1 0
W 01 0123456789abcdef
W 02 fedcba9876543210
W 05 0000000000001000
W 06 ffffffffffffff80
# Write to x0 has no effect
W 00 deadbeefdeadbeef
# add x3, x1, x2
F 0000001004 002081b3 0123456789abcdef fedcba9876543210 0000000000000000 0 1 0
# sub x4, x0, x2
F 0000001008 40200233 0000000000000000 fedcba9876543210 0000000000000000 0 1 0
# addi x7, x5, -16 with rs2 port keeping its last value
F 000000100c ff028393 0000000000001000 fedcba9876543210 fffffffffffffff0 0 1 0
# ld x8, -8(x6)
F 0000001010 ff833403 ffffffffffffff80 fedcba9876543210 fffffffffffffff8 1 1 0
# sd x6, -24(x5)
F 0000001014 fe62b423 0000000000001000 ffffffffffffff80 ffffffffffffffe8 1 0 0
# bne x1, x2, -32
F 0000001018 fe2090e3 0123456789abcdef fedcba9876543210 ffffffffffffffe0 2 0 0
# jal x1, -4
F 0000000ff8 ffdff0ef 0123456789abcdef fedcba9876543210 fffffffffffffffc 3 1 0
# jalr x1, 2047(x5)
F 0000000ffc 7ff280e7 0000000000001000 fedcba9876543210 00000000000007ff 3 1 0
# lui x10, 0x80000
F 0000001800 80000537 0000000000001000 fedcba9876543210 ffffffff80000000 0 1 0
# auipc x14, 0x12345
F 0000001804 12345717 0000000000001000 fedcba9876543210 0000000012345000 0 1 0
# csrrw x11, 0x300, x6
F 0000001808 300315f3 ffffffffffffff80 fedcba9876543210 0000000000000006 4 1 0
# addiw x15, x6, 1
F 000000180c 0013079b ffffffffffffff80 fedcba9876543210 0000000000000001 0 1 0
# addi x0, x1, 5 writes no register
F 0000001810 00508013 0123456789abcdef fedcba9876543210 0000000000000005 0 0 0
# fence
F 0000001814 0ff0000f 0123456789abcdef fedcba9876543210 0000000000000000 1 0 0
# Undefined opcode
F 0000001818 0000007f 0123456789abcdef fedcba9876543210 0000000000000000 5 0 1
# OP-32 with an unused funct3
F 000000181c 0020a1bb 0123456789abcdef fedcba9876543210 0000000000000000 0 1 1
E 0000002000 2 1
E 4000000040 1 0
# or x12, x1, x2 gets poisoned, and x13, x5, x6 does not
F 0000002004 0020e633 0123456789abcdef fedcba9876543210 0000000000000000 0 1 0
X
F 0000002008 0062f6b3 0000000000001000 ffffffffffffff80 0000000000000000 0 1 0
W 01 5555aaaa5555aaaa
F 000000200c 002081b3 5555aaaa5555aaaa fedcba9876543210 0000000000000000 0 1 0

/* vlog.f */
+incdir+include
source/be_pkg.sv
source/be_regfile.sv
source/be_instr_decoder.sv
source/be_scheduler.sv
source/be_issue_top.sv
tb/tb_be_issue.sv
